/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // same encoding as the core's mask field
    typedef enum logic [1:0] {
        SIZE_NONE = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } access_size_e;

    typedef enum logic [1:0] {
        RESP_OKAY  = 2'b00,
        RESP_ERROR = 2'b10  // slverr code
    } resp_e;

    // one bus word seen whole, as halfwords or as bytes
    typedef union packed {
        logic [DATA_W-1:0]   word;
        logic [1:0][15:0]    halves;
        logic [STRB_W-1:0][7:0] bytes;
    } mem_word_u;

    localparam logic [ADDR_W-1:0] SRAM_BASE   = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] CLINT_BASE  = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] CLINT_BYTES = 32'd8;  // mtime lo, mtime hi

endpackage

`default_nettype wire

/* logic/mem_bus_if.sv */
`default_nettype none

interface mem_bus_if import lsu_pkg::*; ();

    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;

    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    resp_e             rresp;

    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;

    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;

    logic              bvalid;
    logic              bready;
    resp_e             bresp;

    modport master (
        output arvalid, araddr, input arready,
        input rvalid, rdata, rresp, output rready,
        output awvalid, awaddr, input awready,
        output wvalid, wdata, wstrb, input wready,
        input bvalid, bresp, output bready
    );

    modport slave (
        input arvalid, araddr, output arready,
        output rvalid, rdata, rresp, input rready,
        input awvalid, awaddr, output awready,
        input wvalid, wdata, wstrb, output wready,
        output bvalid, bresp, input bready
    );

endinterface

`default_nettype wire

/* logic/lsu.sv */
`default_nettype none

module lsu import lsu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              req,
    input  wire logic              ren,
    input  wire logic              wen,
    input  wire logic              sign,
    input  wire access_size_e      size,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic [DATA_W-1:0] wdata,
    output      logic [DATA_W-1:0] rdata,
    output      logic              done,
    output      logic              err,
    mem_bus_if.master              bus
);

    logic              arvalid_q;
    logic              awvalid_q;
    logic              wvalid_q;
    logic              busy;

    logic [STRB_W-1:0] strb_next;
    logic [DATA_W-1:0] lane_next;

    logic [ADDR_W-1:0] addr_q;
    access_size_e      size_q;
    logic              sign_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    mem_word_u         rword_q;

    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;

    logic              start;

    assign start = req && !busy;  // requests while busy are dropped

    // halfword lanes follow addr[1] only, addr[0] is ignored
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                strb_next = 4'b0001 << addr[1:0];
                lane_next = wdata << {addr[1:0], 3'b000};
            end
            SIZE_HALF: begin
                strb_next = addr[1] ? 4'b1100 : 4'b0011;
                lane_next = wdata << {addr[1], 4'b0000};
            end
            SIZE_WORD: begin
                strb_next = 4'b1111;
                lane_next = wdata;
            end
            default: begin
                strb_next = 4'b0000;
                lane_next = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            err       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                if (ren) begin
                    arvalid_q <= 1'b1;
                    busy      <= 1'b1;
                end else if (wen) begin
                    awvalid_q <= 1'b1;
                    wvalid_q  <= 1'b1;
                    busy      <= 1'b1;
                end else begin
                    done <= 1'b1;  // nothing to do, answer at once
                    err  <= 1'b0;
                end
            end
            if (arvalid_q && bus.arready) arvalid_q <= 1'b0;
            if (awvalid_q && bus.awready) awvalid_q <= 1'b0;
            if (wvalid_q && bus.wready)   wvalid_q  <= 1'b0;
            if (bus.rvalid && bus.rready) begin
                done <= 1'b1;
                err  <= (bus.rresp != RESP_OKAY);
                busy <= 1'b0;
            end
            if (bus.bvalid && bus.bready) begin
                done <= 1'b1;
                err  <= (bus.bresp != RESP_OKAY);
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            size_q  <= size;
            sign_q  <= sign;
            wdata_q <= lane_next;
            wstrb_q <= strb_next;
            rword_q <= '0;  // stores and no-ops read back zero
        end
        if (bus.rvalid && bus.rready) rword_q <= bus.rdata;
    end

    assign bus.arvalid = arvalid_q;
    assign bus.araddr  = addr_q;
    assign bus.awvalid = awvalid_q;
    assign bus.awaddr  = addr_q;
    assign bus.wvalid  = wvalid_q;
    assign bus.wdata   = wdata_q;
    assign bus.wstrb   = wstrb_q;
    assign bus.rready  = 1'b1;
    assign bus.bready  = 1'b1;

    assign byte_sel = rword_q.bytes[addr_q[1:0]];
    assign half_sel = rword_q.halves[addr_q[1]];

    always_comb begin
        case (size_q)
            SIZE_BYTE: rdata = {{24{byte_sel[7] & sign_q}}, byte_sel};
            SIZE_HALF: rdata = {{16{half_sel[15] & sign_q}}, half_sel};
            SIZE_WORD: rdata = rword_q.word;
            default:   rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/bus_decoder.sv */
`default_nettype none

module bus_decoder import lsu_pkg::*; #(
    parameter int SRAM_WORDS = 1024
) (
    input wire logic  clk,
    input wire logic  reset,
    mem_bus_if.slave  cpu,
    mem_bus_if.master sram,
    mem_bus_if.master clint
);

    localparam logic [ADDR_W-1:0] SRAM_BYTES = ADDR_W'(SRAM_WORDS * 4);

    logic ar_sram, ar_clint;
    logic aw_sram, aw_clint;
    logic rd_sram_q, rd_clint_q;
    logic wr_sram_q, wr_clint_q;
    logic miss_rvalid_q, miss_bvalid_q;

    function automatic logic in_range(input logic [ADDR_W-1:0] a,
                                      input logic [ADDR_W-1:0] base,
                                      input logic [ADDR_W-1:0] bytes);
        return (a - base) < bytes;  // wraps below base
    endfunction

    assign ar_sram  = in_range(cpu.araddr, SRAM_BASE, SRAM_BYTES);
    assign ar_clint = in_range(cpu.araddr, CLINT_BASE, CLINT_BYTES);
    assign aw_sram  = in_range(cpu.awaddr, SRAM_BASE, SRAM_BYTES);
    assign aw_clint = in_range(cpu.awaddr, CLINT_BASE, CLINT_BYTES);

    assign sram.arvalid  = cpu.arvalid && ar_sram;
    assign clint.arvalid = cpu.arvalid && ar_clint;
    assign sram.araddr   = cpu.araddr;
    assign clint.araddr  = cpu.araddr;
    assign cpu.arready   = ar_sram ? sram.arready : ar_clint ? clint.arready : !miss_rvalid_q;

    assign sram.awvalid  = cpu.awvalid && aw_sram;
    assign clint.awvalid = cpu.awvalid && aw_clint;
    assign sram.awaddr   = cpu.awaddr;
    assign clint.awaddr  = cpu.awaddr;
    assign sram.wvalid   = cpu.wvalid && aw_sram;  // w follows the aw decode
    assign clint.wvalid  = cpu.wvalid && aw_clint;
    assign sram.wdata    = cpu.wdata;
    assign clint.wdata   = cpu.wdata;
    assign sram.wstrb    = cpu.wstrb;
    assign clint.wstrb   = cpu.wstrb;
    assign cpu.awready   = aw_sram ? sram.awready : aw_clint ? clint.awready
                         : (cpu.wvalid && !miss_bvalid_q);
    assign cpu.wready    = aw_sram ? sram.wready : aw_clint ? clint.wready
                         : (cpu.awvalid && !miss_bvalid_q);

    // responses come back from where the request went
    assign sram.rready  = cpu.rready && rd_sram_q;
    assign clint.rready = cpu.rready && rd_clint_q;
    assign cpu.rvalid   = rd_sram_q ? sram.rvalid : rd_clint_q ? clint.rvalid : miss_rvalid_q;
    assign cpu.rdata    = rd_sram_q ? sram.rdata : rd_clint_q ? clint.rdata : '0;
    assign cpu.rresp    = rd_sram_q ? sram.rresp : rd_clint_q ? clint.rresp : RESP_ERROR;

    assign sram.bready  = cpu.bready && wr_sram_q;
    assign clint.bready = cpu.bready && wr_clint_q;
    assign cpu.bvalid   = wr_sram_q ? sram.bvalid : wr_clint_q ? clint.bvalid : miss_bvalid_q;
    assign cpu.bresp    = wr_sram_q ? sram.bresp : wr_clint_q ? clint.bresp : RESP_ERROR;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_sram_q     <= 1'b0;
            rd_clint_q    <= 1'b0;
            wr_sram_q     <= 1'b0;
            wr_clint_q    <= 1'b0;
            miss_rvalid_q <= 1'b0;
            miss_bvalid_q <= 1'b0;
        end else begin
            if (miss_rvalid_q && cpu.rready) miss_rvalid_q <= 1'b0;
            if (miss_bvalid_q && cpu.bready) miss_bvalid_q <= 1'b0;
            if (cpu.arvalid && cpu.arready) begin
                rd_sram_q  <= ar_sram;
                rd_clint_q <= ar_clint;
                if (!ar_sram && !ar_clint) miss_rvalid_q <= 1'b1;  // unmapped read
            end
            if (cpu.awvalid && cpu.awready) begin
                wr_sram_q  <= aw_sram;
                wr_clint_q <= aw_clint;
                if (!aw_sram && !aw_clint) miss_bvalid_q <= 1'b1;  // unmapped write
            end
        end
    end

endmodule

`default_nettype wire

/* logic/data_sram.sv */
`default_nettype none

module data_sram import lsu_pkg::*; #(
    parameter int SRAM_WORDS = 1024
) (
    input wire logic clk,
    input wire logic reset,
    mem_bus_if.slave bus
);

    localparam int IDX_W = $clog2(SRAM_WORDS);

    mem_word_u         mem [SRAM_WORDS];
    mem_word_u         wdata_u;
    logic [ADDR_W-1:0] rd_off, wr_off;
    logic [IDX_W-1:0]  rd_idx, wr_idx;
    logic [DATA_W-1:0] rdata_q;
    logic              rvalid_q, bvalid_q;
    logic              rd_fire, wr_fire;

    assign rd_off  = bus.araddr - SRAM_BASE;
    assign wr_off  = bus.awaddr - SRAM_BASE;
    assign rd_idx  = rd_off[IDX_W+1:2];  // word offset
    assign wr_idx  = wr_off[IDX_W+1:2];
    assign wdata_u = bus.wdata;

    // aw and w are taken together
    assign bus.arready = !rvalid_q;
    assign bus.awready = bus.wvalid && !bvalid_q;
    assign bus.wready  = bus.awvalid && !bvalid_q;

    assign rd_fire = bus.arvalid && bus.arready;
    assign wr_fire = bus.awvalid && bus.awready;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (bus.wstrb[b]) mem[wr_idx].bytes[b] <= wdata_u.bytes[b];
            end
        end
        if (rd_fire) rdata_q <= mem[rd_idx].word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (rvalid_q && bus.rready) rvalid_q <= 1'b0;
            if (bvalid_q && bus.bready) bvalid_q <= 1'b0;
            if (rd_fire) rvalid_q <= 1'b1;
            if (wr_fire) bvalid_q <= 1'b1;
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;
    assign bus.rresp  = RESP_OKAY;
    assign bus.bvalid = bvalid_q;
    assign bus.bresp  = RESP_OKAY;

endmodule

`default_nettype wire

/* logic/clint_timer.sv */
`default_nettype none

module clint_timer import lsu_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    mem_bus_if.slave bus
);

    logic [63:0]       mtime;
    logic [DATA_W-1:0] rdata_q;
    logic              rvalid_q, bvalid_q;
    logic              rd_fire, wr_fire;

    assign bus.arready = !rvalid_q;
    assign bus.awready = bus.wvalid && !bvalid_q;
    assign bus.wready  = bus.awvalid && !bvalid_q;

    assign rd_fire = bus.arvalid && bus.arready;
    assign wr_fire = bus.awvalid && bus.awready;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime    <= '0;
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (rvalid_q && bus.rready) rvalid_q <= 1'b0;
            if (bvalid_q && bus.bready) bvalid_q <= 1'b0;
            if (rd_fire) rvalid_q <= 1'b1;
            if (wr_fire) bvalid_q <= 1'b1;  // write is refused
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) rdata_q <= bus.araddr[2] ? mtime[63:32] : mtime[31:0];
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;
    assign bus.rresp  = RESP_OKAY;
    assign bus.bvalid = bvalid_q;
    assign bus.bresp  = RESP_ERROR;  // mtime is read-only

endmodule

`default_nettype wire

/* logic/lsu_subsystem.sv */
`default_nettype none

module lsu_subsystem import lsu_pkg::*; #(
    parameter int SRAM_WORDS = 1024
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              req,
    input  wire logic              ren,
    input  wire logic              wen,
    input  wire logic              sign,
    input  wire access_size_e      size,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic [DATA_W-1:0] wdata,
    output      logic [DATA_W-1:0] rdata,
    output      logic              done,
    output      logic              err
);

    mem_bus_if cpu_bus ();
    mem_bus_if sram_bus ();
    mem_bus_if clint_bus ();

    lsu u_lsu (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ren   (ren),
        .wen   (wen),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err),
        .bus   (cpu_bus.master)
    );

    bus_decoder #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_bus_decoder (
        .clk   (clk),
        .reset (reset),
        .cpu   (cpu_bus.slave),
        .sram  (sram_bus.master),
        .clint (clint_bus.master)
    );

    data_sram #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_data_sram (
        .clk   (clk),
        .reset (reset),
        .bus   (sram_bus.slave)
    );

    clint_timer u_clint_timer (
        .clk   (clk),
        .reset (reset),
        .bus   (clint_bus.slave)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* verification/lsu_subsystem_asserts.sv */
`default_nettype none

module lsu_subsystem_asserts import lsu_pkg::*; (
    input wire logic              clk,
    input wire logic              reset,
    input wire logic              arvalid,
    input wire logic              arready,
    input wire logic [ADDR_W-1:0] araddr,
    input wire logic              awvalid,
    input wire logic              awready,
    input wire logic [ADDR_W-1:0] awaddr,
    input wire logic              wvalid,
    input wire logic              wready
);

    int unsigned violations = 0;  // read by the testbench at the end

    ar_valid_held: assert property (
        @(posedge clk) disable iff (reset) arvalid && !arready |=> arvalid
    ) else begin
        $error("arvalid dropped before arready");
        violations++;
    end

    ar_addr_stable: assert property (
        @(posedge clk) disable iff (reset) arvalid && !arready |=> $stable(araddr)
    ) else begin
        $error("araddr changed while waiting for arready");
        violations++;
    end

    aw_valid_held: assert property (
        @(posedge clk) disable iff (reset) awvalid && !awready |=> awvalid
    ) else begin
        $error("awvalid dropped before awready");
        violations++;
    end

    aw_addr_stable: assert property (
        @(posedge clk) disable iff (reset) awvalid && !awready |=> $stable(awaddr)
    ) else begin
        $error("awaddr changed while waiting for awready");
        violations++;
    end

    w_valid_held: assert property (
        @(posedge clk) disable iff (reset) wvalid && !wready |=> wvalid
    ) else begin
        $error("wvalid dropped before wready");
        violations++;
    end

endmodule

bind bus_decoder lsu_subsystem_asserts u_asserts (
    .clk     (clk),
    .reset   (reset),
    .arvalid (cpu.arvalid),
    .arready (cpu.arready),
    .araddr  (cpu.araddr),
    .awvalid (cpu.awvalid),
    .awready (cpu.awready),
    .awaddr  (cpu.awaddr),
    .wvalid  (cpu.wvalid),
    .wready  (cpu.wready)
);

`default_nettype wire

/* verification/lsu_subsystem_tb.sv */
`default_nettype none

module lsu_subsystem_tb import lsu_pkg::*; ();

    localparam int PERIOD        = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 5;
    localparam int SRAM_WORDS    = 1024;
    localparam int MODEL_AW      = $clog2(SRAM_WORDS * 4);
    localparam int RANDOM_OPS    = 200;
    localparam int NUM_ACCESSES  = 280;  // all accesses below, rounded up
    localparam int ACCESS_CYCLES = 8;    // req to done takes about five
    localparam int WATCHDOG_TIME = 2 * (RESET_CYCLES + NUM_ACCESSES * ACCESS_CYCLES) * PERIOD;
    localparam logic [31:0] SRAM_BYTES = 32'(SRAM_WORDS * 4);
    localparam logic [31:0] WIN_BASE   = SRAM_BASE + 32'h200;

    logic         clk;
    logic         reset;
    logic         req;
    logic         ren;
    logic         wen;
    logic         sign;
    access_size_e size;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [31:0]  rdata;
    logic         done;
    logic         err;

    logic [7:0]   sram_model [SRAM_WORDS * 4];
    logic         pending;
    logic         exp_err;
    logic         exp_check_data;
    logic [31:0]  exp_rdata;
    logic [31:0]  last_rdata;
    int           checks = 0;
    int           errors = 0;
    int           test_checks = 0;
    int           test_errors = 0;
    integer       seed;

    tb_clock #(.PERIOD(PERIOD)) u_clock (.clk(clk));

    lsu_subsystem #(
        .SRAM_WORDS (SRAM_WORDS)
    ) dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ren   (ren),
        .wen   (wen),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err)
    );

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
    endfunction

    // returns {err, rdata}
    function automatic logic [32:0] expected_result(input logic r, input logic w,
                                                    input access_size_e sz, input logic sgn,
                                                    input logic [31:0] a);
        logic [31:0]         word;
        logic [7:0]          b;
        logic [15:0]         h;
        logic [MODEL_AW-1:0] off;
        logic                hit_sram;
        logic                hit_clint;
        hit_sram  = (a - SRAM_BASE) < SRAM_BYTES;
        hit_clint = (a - CLINT_BASE) < 32'd8;
        off       = MODEL_AW'(a - SRAM_BASE);
        if (!r && !w) return {1'b0, 32'h0};
        if (!r) return {!hit_sram, 32'h0};  // only the sram takes stores
        if (!hit_sram) return {!hit_clint, 32'h0};  // mtime value checked apart
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = sram_model[{off[MODEL_AW-1:2], 2'(i)}];
        end
        b = 8'(word >> (8 * off[1:0]));
        h = 16'(word >> (16 * off[1]));  // halfword sits on its even pair
        case (sz)
            SIZE_BYTE: return {1'b0, sgn ? 32'($signed(b)) : 32'(b)};
            SIZE_HALF: return {1'b0, sgn ? 32'($signed(h)) : 32'(h)};
            SIZE_WORD: return {1'b0, word};
            default:   return {1'b0, 32'h0};
        endcase
    endfunction

    function automatic void apply_store(input access_size_e sz, input logic [31:0] a,
                                        input logic [31:0] d);
        logic [MODEL_AW-1:0] off;
        off = MODEL_AW'(a - SRAM_BASE);
        if ((a - SRAM_BASE) >= SRAM_BYTES) return;
        case (sz)
            SIZE_BYTE: sram_model[off] = d[7:0];
            SIZE_HALF: begin
                sram_model[{off[MODEL_AW-1:1], 1'b0}] = d[7:0];
                sram_model[{off[MODEL_AW-1:1], 1'b1}] = d[15:8];
            end
            SIZE_WORD: begin
                for (int i = 0; i < 4; i++) begin
                    sram_model[{off[MODEL_AW-1:2], 2'(i)}] = d[8*i +: 8];
                end
            end
            default: ;
        endcase
    endfunction

    task automatic issue_access(input logic r, input logic w, input access_size_e sz,
                                input logic sgn, input logic [31:0] a, input logic [31:0] d,
                                input logic check_data);
        logic [32:0] expv;
        expv = expected_result(r, w, sz, sgn, a);
        @(posedge clk);
        #DRIVE_DELAY;
        exp_rdata      = expv[31:0];
        exp_err        = expv[32];
        exp_check_data = check_data;
        pending        = 1'b1;
        req   = 1'b1;
        ren   = r;
        wen   = w;
        size  = sz;
        sign  = sgn;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #DRIVE_DELAY;
        req = 1'b0;
        ren = 1'b0;
        wen = 1'b0;
        do begin
            @(negedge clk);
        end while (done !== 1'b1);
        wait (pending === 1'b0);  // compare of this done has run
        last_rdata = rdata;
        if (w) apply_store(sz, a, d);
    endtask

    task automatic load(input access_size_e sz, input logic sgn, input logic [31:0] a);
        issue_access(1'b1, 1'b0, sz, sgn, a, 32'h0, (a - CLINT_BASE) >= 32'd8);
    endtask

    task automatic store(input access_size_e sz, input logic [31:0] a, input logic [31:0] d);
        issue_access(1'b0, 1'b1, sz, 1'b0, a, d, 1'b1);
    endtask

    task automatic finish_test(input string name);
        $display("test %-26s %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // compares every done against the expected values
    always @(negedge clk) begin
        if (reset === 1'b1) begin
            if (done === 1'b1) begin
                $display("FAILED at %0t: done expected 0, got 1 during reset", $time);
                errors++;
            end
        end else if (done === 1'b1) begin
            if (pending !== 1'b1) begin
                $display("ERROR at %0t: done pulsed with no access in flight", $time);
                errors++;
            end else begin
                checks++;
                if (err !== exp_err) begin
                    $display("FAILED at %0t: err expected %b, got %b", $time, exp_err, err);
                    errors++;
                end
                if (exp_check_data && rdata !== exp_rdata) begin
                    $display("FAILED at %0t: rdata expected %h, got %h", $time, exp_rdata,
                             rdata);
                    errors++;
                end
            end
            pending = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("ERROR at %0t: watchdog expired, an access never finished", $time);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0]  a;
        logic [31:0]  rnd;
        logic [31:0]  mtime_first;
        access_size_e sz;
        seed           = 32'h104f_4788;
        reset          = 1'b1;
        req            = 1'b0;
        ren            = 1'b0;
        wen            = 1'b0;
        sign           = 1'b0;
        size           = SIZE_NONE;
        addr           = 32'h0;
        wdata          = 32'h0;
        pending        = 1'b0;
        exp_err        = 1'b0;
        exp_check_data = 1'b0;
        exp_rdata      = 32'h0;
        last_rdata     = 32'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        for (int i = 0; i < 5; i++) begin
            a = SRAM_BASE + 32'(i * 'h3fc);
            store(SIZE_WORD, a, fill_word(a));
        end
        for (int i = 0; i < 5; i++) begin
            load(SIZE_WORD, 1'b0, SRAM_BASE + 32'(i * 'h3fc));
        end
        finish_test("1 word store and load");

        for (int k = 0; k < 4; k++) begin
            a = SRAM_BASE + 32'h40 + 32'(4 * k) + 32'(k);  // own word, offset k
            store(SIZE_WORD, a, fill_word(a));
            store(SIZE_BYTE, a, $random(seed));
            load(SIZE_WORD, 1'b0, a);
            a = SRAM_BASE + 32'h60 + 32'(4 * k) + 32'(k);
            store(SIZE_WORD, a, fill_word(a));
            store(SIZE_HALF, a, $random(seed));
            load(SIZE_WORD, 1'b0, a);
        end
        finish_test("2 byte and half stores");

        a = SRAM_BASE + 32'h80;
        store(SIZE_WORD, a, 32'h80f1_7f92);  // top bits differ per byte and half
        for (int k = 0; k < 8; k++) begin
            load(SIZE_BYTE, k[2], a + 32'(k[1:0]));
            load(SIZE_HALF, k[2], a + 32'(k[1:0]));
        end
        finish_test("3 byte and half loads");

        load(SIZE_WORD, 1'b0, CLINT_BASE);
        mtime_first = last_rdata;
        load(SIZE_WORD, 1'b0, CLINT_BASE);
        checks++;
        if (last_rdata <= mtime_first) begin
            $display("FAILED at %0t: mtime_lo expected above %h, got %h", $time,
                     mtime_first, last_rdata);
            errors++;
        end
        load(SIZE_WORD, 1'b0, CLINT_BASE + 32'd4);
        checks++;
        if (last_rdata !== 32'h0) begin
            $display("FAILED at %0t: mtime_hi expected %h, got %h", $time, 32'h0,
                     last_rdata);
            errors++;
        end
        finish_test("4 clint mtime reads");

        store(SIZE_WORD, CLINT_BASE, 32'hdead_beef);
        load(SIZE_WORD, 1'b0, 32'h1000_0000);
        store(SIZE_WORD, 32'h1000_0000, 32'h1234_5678);
        issue_access(1'b0, 1'b0, SIZE_WORD, 1'b0, SRAM_BASE, 32'h0, 1'b1);
        finish_test("5 error responses and no-op");

        for (int i = 0; i < 16; i++) begin
            a = WIN_BASE + 32'(4 * i);
            store(SIZE_WORD, a, fill_word(a));
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd = $random(seed);
            sz  = access_size_e'((rnd[9:8] == 2'b00) ? 2'b11 : rnd[9:8]);
            a   = WIN_BASE + 32'(rnd[15:10]);
            if (rnd[0]) begin
                store(sz, a, $random(seed));
            end else begin
                load(sz, rnd[1], a);
            end
        end
        finish_test("6 random mixed accesses");

        $display("summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 dut.u_bus_decoder.u_asserts.violations);
        if (errors == 0 && dut.u_bus_decoder.u_asserts.violations == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_subsystem.f */
logic/lsu_pkg.sv
logic/mem_bus_if.sv
logic/lsu.sv
logic/bus_decoder.sv
logic/data_sram.sv
logic/clint_timer.sv
logic/lsu_subsystem.sv
verification/tb_clock.sv
verification/lsu_subsystem_asserts.sv
verification/lsu_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_subsystem_tb -f lsu_subsystem.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vlsu_subsystem_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
